// File: build.f
+incdir+rtl
rtl/mango_pkg.sv
rtl/mango_fetch.sv
rtl/mango_decode.sv
rtl/mango_regfile.sv
rtl/mango_execute.sv
rtl/mango_core_top.sv
verification/mango_core_properties.sv
verification/mango_core_tb.sv

// File: rtl/mango_config.svh
// Core configuration macros.
// Widths, boot address, fetch step, opcode and function codes.

`ifndef MANGO_CONFIG_SVH
`define MANGO_CONFIG_SVH

// ######################################################################
// widths and addresses
// ######################################################################
`define MANGO_DATA_W       32
`define MANGO_REG_ADDR_W   5
`define MANGO_RESET_PC     32'hBFC0_0000
`define MANGO_PC_STEP      32'd4

// ######################################################################
// opcodes and function codes
// ######################################################################
`define MANGO_OP_SPECIAL   6'h00
`define MANGO_OP_ADDIU     6'h09
`define MANGO_OP_ORI       6'h0D
`define MANGO_OP_LUI       6'h0F

`define MANGO_FN_ADDU      6'h21
`define MANGO_FN_SUBU      6'h23
`define MANGO_FN_AND       6'h24
`define MANGO_FN_OR        6'h25
`define MANGO_FN_XOR       6'h26
`define MANGO_FN_SLT       6'h2A
`define MANGO_FN_SLTU      6'h2B

`endif

// File: rtl/mango_core_top.sv
// Core top level.
// Fetch, decode, register file and execute, plus the debug write-back ports.

`timescale 1ns/1ps
`default_nettype none

module mango_core_top import mango_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,

    output logic      ibus_en_o,
    output word_t     ibus_addr_o,
    input  word_t     ibus_rdata_i,
    input  logic      ibus_stall_i,

    output word_t     debug_wb_pc_o,
    output logic      debug_wb_wen_o,
    output reg_addr_t debug_wb_wraddr_o,
    output word_t     debug_wb_wrdata_o
);

    logic      id_valid;
    word_t     id_pc;
    word_t     id_inst;

    reg_addr_t r1_addr;
    reg_addr_t r2_addr;
    word_t     r1_data;
    word_t     r2_data;

    logic      ex_valid;
    word_t     ex_pc;
    alu_op_e   ex_aluop;
    word_t     ex_opr1;
    word_t     ex_opr2;
    logic      ex_wreg;
    reg_addr_t ex_wraddr;
    word_t     ex_result;

    word_t     wb_pc;
    logic      wb_wreg;
    reg_addr_t wb_wraddr;
    word_t     wb_wrdata;

    mango_fetch mango_fetch_i (
        .clk_i        (clk_i       ),
        .arst_n_i     (arst_n_i    ),
        .ibus_stall_i (ibus_stall_i),
        .ibus_rdata_i (ibus_rdata_i),
        .ibus_en_o    (ibus_en_o   ),
        .ibus_addr_o  (ibus_addr_o ),
        .id_valid_o   (id_valid    ),
        .id_pc_o      (id_pc       ),
        .id_inst_o    (id_inst     )
    );

    mango_decode mango_decode_i (
        .clk_i       (clk_i    ),
        .arst_n_i    (arst_n_i ),
        .id_valid_i  (id_valid ),
        .id_pc_i     (id_pc    ),
        .id_inst_i   (id_inst  ),
        .r1_addr_o   (r1_addr  ),
        .r2_addr_o   (r2_addr  ),
        .r1_data_i   (r1_data  ),
        .r2_data_i   (r2_data  ),
        .ex_valid_o  (ex_valid ),
        .ex_pc_o     (ex_pc    ),
        .ex_aluop_o  (ex_aluop ),
        .ex_opr1_o   (ex_opr1  ),
        .ex_opr2_o   (ex_opr2  ),
        .ex_wreg_o   (ex_wreg  ),
        .ex_wraddr_o (ex_wraddr)
    );

    mango_regfile mango_regfile_i (
        .clk_i       (clk_i    ),
        .arst_n_i    (arst_n_i ),
        .r1_addr_i   (r1_addr  ),
        .r2_addr_i   (r2_addr  ),
        .r1_data_o   (r1_data  ),
        .r2_data_o   (r2_data  ),
        .ex_wreg_i   (ex_wreg  ),
        .ex_wraddr_i (ex_wraddr),
        .ex_result_i (ex_result),
        .wb_wreg_i   (wb_wreg  ),
        .wb_wraddr_i (wb_wraddr),
        .wb_wrdata_i (wb_wrdata)
    );

    mango_execute mango_execute_i (
        .clk_i       (clk_i    ),
        .arst_n_i    (arst_n_i ),
        .ex_valid_i  (ex_valid ),
        .ex_pc_i     (ex_pc    ),
        .ex_aluop_i  (ex_aluop ),
        .ex_opr1_i   (ex_opr1  ),
        .ex_opr2_i   (ex_opr2  ),
        .ex_wreg_i   (ex_wreg  ),
        .ex_wraddr_i (ex_wraddr),
        .ex_result_o (ex_result),
        .wb_pc_o     (wb_pc    ),
        .wb_wreg_o   (wb_wreg  ),
        .wb_wraddr_o (wb_wraddr),
        .wb_wrdata_o (wb_wrdata)
    );

    // retirement trace.
    assign debug_wb_pc_o     = wb_pc;
    assign debug_wb_wen_o    = wb_wreg;
    assign debug_wb_wraddr_o = wb_wraddr;
    assign debug_wb_wrdata_o = wb_wrdata;

endmodule

`default_nettype wire

// File: rtl/mango_decode.sv
// Decode stage.
// Field split, ALU op mapping, operand select, decode-to-execute register.

`timescale 1ns/1ps
`default_nettype none

`include "mango_config.svh"

module mango_decode import mango_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      id_valid_i,
    input  word_t     id_pc_i,
    input  word_t     id_inst_i,
    output reg_addr_t r1_addr_o,
    output reg_addr_t r2_addr_o,
    input  word_t     r1_data_i,
    input  word_t     r2_data_i,
    output logic      ex_valid_o,
    output word_t     ex_pc_o,
    output alu_op_e   ex_aluop_o,
    output word_t     ex_opr1_o,
    output word_t     ex_opr2_o,
    output logic      ex_wreg_o,
    output reg_addr_t ex_wraddr_o
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;

    alu_op_e     aluop;
    reg_addr_t   dest;
    word_t       imm_ext;
    logic        use_imm;
    logic        known;

    assign opcode = id_inst_i[31:26];
    assign rs     = reg_addr_t'(id_inst_i[25:21]);
    assign rt     = reg_addr_t'(id_inst_i[20:16]);
    assign rd     = reg_addr_t'(id_inst_i[15:11]);
    assign funct  = id_inst_i[5:0];
    assign imm    = id_inst_i[15:0];

    assign r1_addr_o = rs;
    assign r2_addr_o = rt;

    // ##################################################################
    // instruction decode
    // ##################################################################
    always_comb begin
        aluop   = ALU_ADD;
        dest    = rd;
        imm_ext = word_t'(imm);                    // zero-extended.
        use_imm = 1'b0;
        known   = 1'b1;
        case (opcode)
            `MANGO_OP_SPECIAL: begin
                case (funct)
                    `MANGO_FN_ADDU: aluop = ALU_ADD;
                    `MANGO_FN_SUBU: aluop = ALU_SUB;
                    `MANGO_FN_AND:  aluop = ALU_AND;
                    `MANGO_FN_OR:   aluop = ALU_OR;
                    `MANGO_FN_XOR:  aluop = ALU_XOR;
                    `MANGO_FN_SLT:  aluop = ALU_SLT;
                    `MANGO_FN_SLTU: aluop = ALU_SLTU;
                    default:        known = 1'b0;
                endcase
            end
            `MANGO_OP_ADDIU: begin
                aluop   = ALU_ADD;
                dest    = rt;
                use_imm = 1'b1;
                imm_ext = word_t'(signed'(imm));   // sign-extended.
            end
            `MANGO_OP_ORI: begin
                aluop   = ALU_OR;
                dest    = rt;
                use_imm = 1'b1;
            end
            `MANGO_OP_LUI: begin
                aluop   = ALU_LUI;
                dest    = rt;
                use_imm = 1'b1;
            end
            default: known = 1'b0;                 // retires as a no-op.
        endcase
    end

    // ##################################################################
    // decode-to-execute register
    // ##################################################################
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_valid_o <= 1'b0;
            ex_wreg_o  <= 1'b0;
        end else begin
            ex_valid_o <= id_valid_i;
            ex_wreg_o  <= id_valid_i && known && (dest != '0);
        end
    end

    always_ff @(posedge clk_i) begin
        ex_pc_o     <= id_pc_i;
        ex_aluop_o  <= aluop;
        ex_opr1_o   <= r1_data_i;
        ex_opr2_o   <= use_imm ? imm_ext : r2_data_i;
        ex_wraddr_o <= dest;
    end

endmodule

`default_nettype wire

// File: rtl/mango_execute.sv
// Execute stage.
// ALU and the execute-to-write-back register.

`timescale 1ns/1ps
`default_nettype none

`include "mango_config.svh"

module mango_execute import mango_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      ex_valid_i,
    input  word_t     ex_pc_i,
    input  alu_op_e   ex_aluop_i,
    input  word_t     ex_opr1_i,
    input  word_t     ex_opr2_i,
    input  logic      ex_wreg_i,
    input  reg_addr_t ex_wraddr_i,
    output word_t     ex_result_o,
    output word_t     wb_pc_o,
    output logic      wb_wreg_o,
    output reg_addr_t wb_wraddr_o,
    output word_t     wb_wrdata_o
);

    localparam int HALF_W = `MANGO_DATA_W / 2;

    // ##################################################################
    // ALU
    // ##################################################################
    always_comb begin
        case (ex_aluop_i)
            ALU_ADD:  ex_result_o = ex_opr1_i + ex_opr2_i;   // wraps.
            ALU_SUB:  ex_result_o = ex_opr1_i - ex_opr2_i;
            ALU_AND:  ex_result_o = ex_opr1_i & ex_opr2_i;
            ALU_OR:   ex_result_o = ex_opr1_i | ex_opr2_i;
            ALU_XOR:  ex_result_o = ex_opr1_i ^ ex_opr2_i;
            ALU_SLT:  ex_result_o = word_t'($signed(ex_opr1_i) < $signed(ex_opr2_i));
            ALU_SLTU: ex_result_o = word_t'(ex_opr1_i < ex_opr2_i);
            ALU_LUI:  ex_result_o = {ex_opr2_i[HALF_W-1:0], {HALF_W{1'b0}}};
            default:  ex_result_o = '0;
        endcase
    end

    // ##################################################################
    // execute-to-write-back register
    // ##################################################################
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_wreg_o <= 1'b0;
        end else begin
            wb_wreg_o <= ex_valid_i & ex_wreg_i;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_pc_o     <= ex_pc_i;
        wb_wraddr_o <= ex_wraddr_i;
        wb_wrdata_o <= ex_result_o;
    end

endmodule

`default_nettype wire

// File: rtl/mango_fetch.sv
// Fetch stage.
// Program counter, instruction bus request, fetch-to-decode register.

`timescale 1ns/1ps
`default_nettype none

`include "mango_config.svh"

module mango_fetch import mango_pkg::*; (
    input  logic  clk_i,
    input  logic  arst_n_i,
    input  logic  ibus_stall_i,
    input  word_t ibus_rdata_i,
    output logic  ibus_en_o,
    output word_t ibus_addr_o,
    output logic  id_valid_o,
    output word_t id_pc_o,
    output word_t id_inst_o
);

    word_t pc_q;
    logic  fetch_ok;

    assign ibus_en_o   = 1'b1;           // core always fetches.
    assign ibus_addr_o = pc_q;
    assign fetch_ok    = ibus_en_o & ~ibus_stall_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q       <= `MANGO_RESET_PC;
            id_valid_o <= 1'b0;
        end else begin
            id_valid_o <= fetch_ok;      // bubble while stalled.
            if (fetch_ok) begin
                pc_q <= pc_q + `MANGO_PC_STEP;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch_ok) begin
            id_pc_o   <= pc_q;
            id_inst_o <= ibus_rdata_i;
        end
    end

endmodule

`default_nettype wire

// File: rtl/mango_pkg.sv
// Core types: data word, register index, ALU operation.

`default_nettype none

`include "mango_config.svh"

package mango_pkg;

    typedef logic [`MANGO_DATA_W-1:0]     word_t;     // data or address.
    typedef logic [`MANGO_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI
    } alu_op_e;

endpackage

`default_nettype wire

// File: rtl/mango_regfile.sv
// Register file.
// 32 entries, register 0 fixed at zero, EX and WB bypass on both reads.

`timescale 1ns/1ps
`default_nettype none

`include "mango_config.svh"

module mango_regfile import mango_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  reg_addr_t r1_addr_i,
    input  reg_addr_t r2_addr_i,
    output word_t     r1_data_o,
    output word_t     r2_data_o,
    input  logic      ex_wreg_i,
    input  reg_addr_t ex_wraddr_i,
    input  word_t     ex_result_i,
    input  logic      wb_wreg_i,
    input  reg_addr_t wb_wraddr_i,
    input  word_t     wb_wrdata_i
);

    localparam int NUM_REGS = 2 ** `MANGO_REG_ADDR_W;

    word_t regs [NUM_REGS];

    // youngest result wins.
    function automatic word_t bypass_read(input reg_addr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (ex_wreg_i && (ex_wraddr_i == addr)) begin
            value = ex_result_i;
        end else if (wb_wreg_i && (wb_wraddr_i == addr)) begin
            value = wb_wrdata_i;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        r1_data_o = bypass_read(r1_addr_i);
        r2_data_o = bypass_read(r2_addr_i);
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_wreg_i && (wb_wraddr_i != '0)) begin
            regs[wb_wraddr_i] <= wb_wrdata_i;  // entry 0 never written.
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Compiles the core testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f build.f \
    --top-module mango_core_tb \
    -o mango_core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile step failed with status $status"
    exit $status
fi

./obj_dir/mango_core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

// File: verification/mango_core_properties.sv
// Concurrent checks bound to the core top level.
// Reset state, fetch address order, register 0 writes, retirement latency.

`timescale 1ns/1ps
`default_nettype none

`include "mango_config.svh"

module mango_core_properties import mango_pkg::*; (
    input logic      clk_i,
    input logic      arst_n_i,
    input logic      ibus_en_i,
    input word_t     ibus_addr_i,
    input logic      ibus_stall_i,
    input word_t     debug_wb_pc_i,
    input logic      debug_wb_wen_i,
    input reg_addr_t debug_wb_wraddr_i
);

    logic accepted;

    assign accepted = ibus_en_i & ~ibus_stall_i;   // word taken this cycle.

    // ######################################################################
    // reset and fetch order
    // ######################################################################
    reset_pc: assert property (@(posedge clk_i) $rose(arst_n_i) |-> ibus_addr_i == `MANGO_RESET_PC)
        else $error("error: ibus_addr_o 0x%h after reset, expected 0x%h",
                    $sampled(ibus_addr_i), `MANGO_RESET_PC);

    reset_quiet: assert property (@(posedge clk_i)
        (!arst_n_i || $rose(arst_n_i)) |-> ibus_en_i && !debug_wb_wen_i)
        else $error("fetch disabled or a write retired while coming out of reset");

    fetch_step: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        accepted |=> ibus_addr_i == $past(ibus_addr_i) + `MANGO_PC_STEP)
        else $error("error: ibus_addr_o 0x%h did not advance by 4", $sampled(ibus_addr_i));

    fetch_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ibus_stall_i |=> ibus_addr_i == $past(ibus_addr_i))
        else $error("error: ibus_addr_o 0x%h moved under stall", $sampled(ibus_addr_i));

    // ######################################################################
    // retirement
    // ######################################################################
    no_zero_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        debug_wb_wen_i |-> debug_wb_wraddr_i != '0)
        else $error("a write to register 0 appeared on the debug ports");

    retire_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        debug_wb_wen_i |-> $past(accepted, 3) && debug_wb_pc_i == $past(ibus_addr_i, 3))
        else $error("error: debug_wb_pc_o 0x%h not fetched three cycles earlier",
                    $sampled(debug_wb_pc_i));

endmodule

`default_nettype wire

// File: verification/mango_core_tb.sv
// Testbench for the core top level.
// Clock, reset, instruction memory, reference model, stall stimulus,
// retirement checks and watchdog.

`timescale 1ns/1ps
`default_nettype none

`include "mango_config.svh"

module mango_core_tb import mango_pkg::*; ();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 4;
    localparam int DRIVE_DELAY  = 1;
    localparam int STALL_MAX    = 3;       // longest run of stalled cycles.
    localparam int PIPE_DEPTH   = 4;
    localparam int MARGIN       = 16;
    localparam int IMEM_AW      = 6;
    localparam int IMEM_WORDS   = 1 << IMEM_AW;
    localparam logic [5:0] FILL_OP = 6'h3F; // not a kept opcode.

    typedef struct packed {
        word_t     pc;
        reg_addr_t addr;
        word_t     data;
    } retire_t;

    logic      clk_i;
    logic      arst_n_i;
    logic      ibus_en_o;
    word_t     ibus_addr_o;
    word_t     ibus_rdata_i;
    logic      ibus_stall_i;
    word_t     debug_wb_pc_o;
    logic      debug_wb_wen_o;
    reg_addr_t debug_wb_wraddr_o;
    word_t     debug_wb_wrdata_o;

    word_t     imem [IMEM_WORDS];
    word_t     word_idx;
    logic      in_range;
    word_t     prog_q [$];
    retire_t   exp_q [$];
    word_t     ref_regs [32];
    int        expected_total;
    int        retired_count;
    logic      prog_built;
    integer    seed = 93839;

    mango_core_top mango_core_top_i (
        .clk_i             (clk_i            ),
        .arst_n_i          (arst_n_i         ),
        .ibus_en_o         (ibus_en_o        ),
        .ibus_addr_o       (ibus_addr_o      ),
        .ibus_rdata_i      (ibus_rdata_i     ),
        .ibus_stall_i      (ibus_stall_i     ),
        .debug_wb_pc_o     (debug_wb_pc_o    ),
        .debug_wb_wen_o    (debug_wb_wen_o   ),
        .debug_wb_wraddr_o (debug_wb_wraddr_o),
        .debug_wb_wrdata_o (debug_wb_wrdata_o)
    );

    bind mango_core_top mango_core_properties mango_core_properties_i (
        .clk_i             (clk_i            ),
        .arst_n_i          (arst_n_i         ),
        .ibus_en_i         (ibus_en_o        ),
        .ibus_addr_i       (ibus_addr_o      ),
        .ibus_stall_i      (ibus_stall_i     ),
        .debug_wb_pc_i     (debug_wb_pc_o    ),
        .debug_wb_wen_i    (debug_wb_wen_o   ),
        .debug_wb_wraddr_i (debug_wb_wraddr_o)
    );

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // memory answers in the same cycle.
    assign word_idx     = (ibus_addr_o - `MANGO_RESET_PC) >> 2;
    assign in_range     = word_idx < word_t'(IMEM_WORDS);
    assign ibus_rdata_i = in_range ? imem[word_idx[IMEM_AW-1:0]] : fill_word(ibus_addr_o);

    // ######################################################################
    // program and reference model
    // ######################################################################
    function automatic word_t fill_word(input word_t addr);
        return {FILL_OP, addr[25:0] ^ addr[31:6]};   // no-op, whole address.
    endfunction

    function automatic word_t rtype_word(input int rd, input int rs, input int rt,
                                         input logic [5:0] funct);
        return {`MANGO_OP_SPECIAL, reg_addr_t'(rs), reg_addr_t'(rt), reg_addr_t'(rd),
                5'd0, funct};
    endfunction

    function automatic word_t itype_word(input logic [5:0] op, input int rt, input int rs,
                                         input int imm);
        return {op, reg_addr_t'(rs), reg_addr_t'(rt), 16'(imm)};
    endfunction

    task automatic build_program();
        prog_q.push_back(itype_word(`MANGO_OP_LUI,   1, 0, 'h7FFF));
        prog_q.push_back(itype_word(`MANGO_OP_ORI,   1, 1, 'hFFFF));
        prog_q.push_back(itype_word(`MANGO_OP_ADDIU, 2, 0, 'h0001));
        prog_q.push_back(itype_word(`MANGO_OP_ADDIU, 4, 0, 'hFFFF));  // -1.
        prog_q.push_back(rtype_word(3, 1, 2, `MANGO_FN_ADDU));         // wraps.
        prog_q.push_back(rtype_word(5, 2, 4, `MANGO_FN_SUBU));
        prog_q.push_back(rtype_word(6, 0, 2, `MANGO_FN_SUBU));
        prog_q.push_back(rtype_word(7, 1, 4, `MANGO_FN_AND));
        prog_q.push_back(rtype_word(8, 2, 3, `MANGO_FN_OR));
        prog_q.push_back(rtype_word(9, 1, 4, `MANGO_FN_XOR));
        prog_q.push_back(rtype_word(10, 4, 2, `MANGO_FN_SLT));
        prog_q.push_back(rtype_word(11, 4, 2, `MANGO_FN_SLTU));
        prog_q.push_back(rtype_word(12, 2, 4, `MANGO_FN_SLT));
        prog_q.push_back(rtype_word(13, 2, 4, `MANGO_FN_SLTU));
        prog_q.push_back(itype_word(`MANGO_OP_ORI,   14, 0, 'h8001));
        prog_q.push_back(itype_word(`MANGO_OP_LUI,   15, 0, 'hABCD));
        prog_q.push_back(itype_word(`MANGO_OP_ADDIU, 16, 15, 'h8000));
        prog_q.push_back(rtype_word(0, 1, 2, `MANGO_FN_ADDU));         // dropped write.
        prog_q.push_back(rtype_word(17, 0, 15, `MANGO_FN_OR));
        prog_q.push_back(itype_word(FILL_OP, 3, 1, 'h1234));
        prog_q.push_back(rtype_word(5, 1, 2, 6'h3F));
        prog_q.push_back(itype_word(`MANGO_OP_ADDIU, 18, 0, 10));
        prog_q.push_back(itype_word(`MANGO_OP_ADDIU, 18, 18, 10));
        prog_q.push_back(itype_word(`MANGO_OP_ADDIU, 18, 18, 10));
        prog_q.push_back(rtype_word(18, 18, 2, `MANGO_FN_SUBU));
        prog_q.push_back(itype_word(`MANGO_OP_ADDIU, 19, 0, 5));
        prog_q.push_back(itype_word(`MANGO_OP_ADDIU, 20, 0, 6));
        prog_q.push_back(rtype_word(19, 19, 20, `MANGO_FN_ADDU));
        prog_q.push_back(rtype_word(20, 19, 20, `MANGO_FN_XOR));
        prog_q.push_back(rtype_word(21, 19, 20, `MANGO_FN_AND));
        prog_q.push_back(itype_word(`MANGO_OP_ADDIU, 22, 0, 0));
    endtask

    task automatic run_reference();
        word_t       inst;
        word_t       opa;
        word_t       opb;
        word_t       res;
        logic [15:0] imm;
        reg_addr_t   dest;
        logic        known;
        retire_t     entry;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        for (int i = 0; i < prog_q.size(); i++) begin
            inst  = prog_q[i];
            opa   = ref_regs[inst[25:21]];
            opb   = ref_regs[inst[20:16]];
            imm   = inst[15:0];
            dest  = inst[15:11];
            known = 1'b1;
            res   = '0;
            case (inst[31:26])
                `MANGO_OP_SPECIAL: begin
                    case (inst[5:0])
                        `MANGO_FN_ADDU: res = opa + opb;
                        `MANGO_FN_SUBU: res = opa - opb;
                        `MANGO_FN_AND:  res = opa & opb;
                        `MANGO_FN_OR:   res = opa | opb;
                        `MANGO_FN_XOR:  res = opa ^ opb;
                        `MANGO_FN_SLT:  res = ($signed(opa) < $signed(opb)) ? 32'd1 : 32'd0;
                        `MANGO_FN_SLTU: res = (opa < opb) ? 32'd1 : 32'd0;
                        default:        known = 1'b0;
                    endcase
                end
                `MANGO_OP_ADDIU: begin
                    res  = opa + {{16{imm[15]}}, imm};
                    dest = inst[20:16];
                end
                `MANGO_OP_ORI: begin
                    res  = opa | {16'h0000, imm};
                    dest = inst[20:16];
                end
                `MANGO_OP_LUI: begin
                    res  = {imm, 16'h0000};
                    dest = inst[20:16];
                end
                default: known = 1'b0;
            endcase
            if (known && dest != '0) begin
                ref_regs[dest] = res;
                entry.pc       = `MANGO_RESET_PC + word_t'(i) * `MANGO_PC_STEP;
                entry.addr     = dest;
                entry.data     = res;
                exp_q.push_back(entry);
            end
        end
        expected_total = exp_q.size();
    endtask

    task automatic load_imem();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            if (i < prog_q.size()) begin
                imem[i] = prog_q[i];
            end else begin
                imem[i] = fill_word(`MANGO_RESET_PC + word_t'(i) * `MANGO_PC_STEP);
            end
        end
    endtask

    // ######################################################################
    // failure reporting
    // ######################################################################
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string name, input word_t expected,
                                   input word_t actual);
        fail_run($sformatf("error: %s expected 0x%h actual 0x%h", name, expected, actual));
    endtask

    // ######################################################################
    // stimulus, checks, watchdog
    // ######################################################################
    initial begin
        int stall_run;
        stall_run    = 0;
        ibus_stall_i = 1'b0;
        wait (arst_n_i === 1'b1);
        forever begin
            @(posedge clk_i);
            #DRIVE_DELAY;
            if (stall_run >= STALL_MAX) begin
                ibus_stall_i = 1'b0;              // cap the stall run.
            end else begin
                ibus_stall_i = ($unsigned($random(seed)) % 3) == 0;
            end
            stall_run = ibus_stall_i ? stall_run + 1 : 0;
        end
    end

    // outputs settle long before the falling edge.
    always @(negedge clk_i) begin
        retire_t head;
        if (debug_wb_wen_o) begin
            if (exp_q.size() == 0) begin
                fail_run("a register write retired after the last expected one");
            end else begin
                head = exp_q[0];
                assert (debug_wb_pc_o == head.pc)
                    else report_mismatch("debug_wb_pc_o", head.pc, debug_wb_pc_o);
                assert (debug_wb_wraddr_o == head.addr)
                    else report_mismatch("debug_wb_wraddr_o", word_t'(head.addr),
                                         word_t'(debug_wb_wraddr_o));
                assert (debug_wb_wrdata_o == head.data)
                    else report_mismatch("debug_wb_wrdata_o", head.data, debug_wb_wrdata_o);
                void'(exp_q.pop_front());
                retired_count++;
            end
        end
    end

    initial begin
        int limit_cycles;
        wait (prog_built === 1'b1);
        limit_cycles = prog_q.size() * (1 + STALL_MAX) + PIPE_DEPTH + RESET_CYCLES + MARGIN;
        #(limit_cycles * CLK_PERIOD);
        fail_run("timeout: the program did not retire in the allowed time");
    end

    initial begin
        arst_n_i      = 1'b0;
        retired_count = 0;
        prog_built    = 1'b0;
        build_program();
        run_reference();
        load_imem();
        prog_built = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY;
        arst_n_i = 1'b1;
        // last program word taken.
        while (ibus_addr_o != `MANGO_RESET_PC + word_t'(prog_q.size()) * `MANGO_PC_STEP) begin
            @(negedge clk_i);
        end
        repeat (PIPE_DEPTH + 2) @(posedge clk_i);    // no write may follow.
        if (exp_q.size() == 0 && retired_count == expected_total) begin
            $display("Testbench passed");
            $finish;
        end else begin
            fail_run("the retired writes do not match the program");
        end
    end

endmodule

`default_nettype wire
